// File: caravel_host.f
+incdir+include
logic/caravel_host_pkg.sv
logic/wb_address_router.sv
logic/wb_peripheral_bridge.sv
logic/uart_device.sv
logic/peripheral_read_collector.sv
logic/caravel_host.sv
verif/caravel_host_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing
TOP = caravel_host_tb
FILELIST = caravel_host.f
BUILD_DIR = obj_dir
LOG = sim.log
PASS_MSG = PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/caravel_host_cases.txt
# op addr wdata expect, all hex; expect is compared on op 1 only
# op 0 write, 1 read, 2 one-byte loopback, 3 back-to-back loopback
1 30001234 00000000 5a5a486e
1 3abcdef0 00000000 50e684aa
1 3e000004 00000000 545a5a5e
0 30000100 deadbeef 00000000
0 3abcdef0 0000a5c3 00000000
1 20000010 00000000 00000000
0 10000000 cafef00d 00000000
1 ff000000 00000000 00000000
1 3f020000 00000000 ffffffff
1 3f0f0008 00000000 ffffffff
1 3f000000 00000000 00000000
1 3f010000 00000000 00000000
1 3f00000c 00000000 00000010
1 3f01000c 00000000 00000010
0 3f00000c 00012345 00000000
1 3f00000c 00000000 00002345
0 3f00000c 0000000c 00000000
1 3f00000c 00000000 0000000c
0 3f01000c 00000014 00000000
1 3f01000c 00000000 00000014
2 3f000004 00000000 00000000
1 3f010000 00000000 00000000
1 3f000000 00000000 00000000
2 3f010004 00000000 00000000
1 3f000000 00000000 00000000
3 3f010004 00000000 00000000
3 3f000004 00000000 00000000
1 3f000000 00000000 00000000
1 3f010000 00000000 00000000

// File: verif/caravel_host_tb.sv
`timescale 1ns/10ps
`include "caravel_host_defines.svh"

module caravel_host_tb;

	logic wb_clk_i = 1'b0;
	logic reset_i = 1'b1;
	caravel_host_pkg::wb_req_t wbs_req = '0;
	caravel_host_pkg::wb_rsp_t wbs_rsp;
	caravel_host_pkg::wb_req_t caravel_req;
	caravel_host_pkg::wb_rsp_t caravel_rsp = '0;
	caravel_host_pkg::wb_req_t seen_req = '0;
	logic [`CH_NUM_UARTS-1:0] uart_rx;
	logic [`CH_NUM_UARTS-1:0] uart_tx;
	logic [3:0] irq;

	logic [31:0] op_q[$];
	logic [31:0] adr_q[$];
	logic [31:0] wdat_q[$];
	logic [31:0] exp_q[$];
	int check_count = 0;
	int error_count = 0;
	int cycle_count = 0;
	int cycle_limit = 1000;
	logic [31:0] rng_state = 32'h67fbd401;
	bit loaded;

	always #5 wb_clk_i = ~wb_clk_i;

	// Each UART talks to itself
	assign uart_rx = uart_tx;

	caravel_host UUT (
		.wb_clk_i(wb_clk_i),
		.reset_i(reset_i),
		.wbs_req_i(wbs_req),
		.wbs_rsp_o(wbs_rsp),
		.caravel_req_o(caravel_req),
		.caravel_rsp_i(caravel_rsp),
		.uart_rx_i(uart_rx),
		.uart_tx_o(uart_tx),
		.irq_o(irq)
	);

	// User-area slave acks one cycle after stb
	always @(posedge wb_clk_i) begin
		if (reset_i) begin
			caravel_rsp <= '0;
		end else if (caravel_req.cyc && caravel_req.stb && !caravel_rsp.ack) begin
			caravel_rsp.ack <= 1'b1;
			caravel_rsp.dat <= {4'h0, caravel_req.adr[27:0]} ^ 32'h5A5A5A5A;
			seen_req <= caravel_req;
		end else begin
			caravel_rsp.ack <= 1'b0;
		end
	end

	always @(posedge wb_clk_i) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [7:0] next_byte();
		rng_state = xorshift32(rng_state);
		return rng_state[7:0];
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic load_cases(output bit ok);
		int fd;
		int n;
		string line;
		logic [31:0] op;
		logic [31:0] adr;
		logic [31:0] wdat;
		logic [31:0] exp_data;
		ok = 1'b0;
		fd = $fopen("verif/caravel_host_cases.txt", "r");
		if (fd != 0) begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				// Comment and blank lines do not scan as four fields
				if (n > 0 && $sscanf(line, "%h %h %h %h", op, adr, wdat, exp_data) == 4) begin
					op_q.push_back(op);
					adr_q.push_back(adr);
					wdat_q.push_back(wdat);
					exp_q.push_back(exp_data);
				end
			end
			$fclose(fd);
			ok = op_q.size() > 0;
			cycle_limit = op_q.size() * 12 * 10 * `CH_UART_DEFAULT_DIV + 100;
		end
	endtask

	task automatic apply_reset();
		repeat (8) @(posedge wb_clk_i);
		reset_i <= 1'b0;
		@(posedge wb_clk_i);
	endtask

	// One classic Wishbone cycle held until ack
	task automatic transfer(input logic write, input logic [31:0] adr,
		input logic [31:0] wdat, output logic [31:0] rdat);
		caravel_host_pkg::wb_req_t req;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we = write;
		req.sel = 4'hF;
		req.adr = adr;
		req.dat = wdat;
		@(posedge wb_clk_i);
		wbs_req <= req;
		@(posedge wb_clk_i);
		while (!wbs_rsp.ack) @(posedge wb_clk_i);
		rdat = wbs_rsp.dat;
		check_value("wbs_rsp_o.err", 32'(wbs_rsp.err), 32'd0);
		wbs_req <= '0;
	endtask

	task automatic wait_for_irq(input int dev);
		while (!irq[dev]) @(posedge wb_clk_i);
	endtask

	task automatic verify_reset_state();
		check_value("caravel_req_o.cyc", 32'(caravel_req.cyc), 32'd0);
		check_value("uart_tx_o", 32'(uart_tx), 32'((1 << `CH_NUM_UARTS) - 1));
		check_value("irq_o", 32'(irq), 32'd0);
		$display("reset state: %s", error_count == 0 ? "ok" : "failed");
	endtask

	task automatic single_loopback(input logic [31:0] adr);
		logic [31:0] rd;
		logic [7:0] data;
		int dev;
		dev = int'(adr[19:16]);
		data = next_byte();
		transfer(1'b1, adr, {24'h0, data}, rd);
		wait_for_irq(dev);
		check_value("irq_o other bits", 32'(irq & ~(4'b1 << dev)), 32'd0);
		transfer(1'b0, {adr[31:16], `CH_REG_STATUS}, 32'd0, rd);
		check_value("status rx valid", 32'(rd[1]), 32'd1);
		transfer(1'b0, {adr[31:16], `CH_REG_RXDATA}, 32'd0, rd);
		check_value("wbs_rsp_o.dat", rd, 32'(data));
		check_value("irq_o", 32'(irq[dev]), 32'd0);
	endtask

	// Second write is held off by busy until the first frame is out
	task automatic double_loopback(input logic [31:0] adr);
		logic [31:0] rd;
		logic [7:0] first;
		logic [7:0] second;
		int dev;
		dev = int'(adr[19:16]);
		first = next_byte();
		second = next_byte();
		transfer(1'b1, adr, {24'h0, first}, rd);
		transfer(1'b1, adr, {24'h0, second}, rd);
		check_value("irq_o at second ack", 32'(irq[dev]), 32'd1);
		transfer(1'b0, {adr[31:16], `CH_REG_RXDATA}, 32'd0, rd);
		check_value("wbs_rsp_o.dat first byte", rd, 32'(first));
		check_value("irq_o", 32'(irq[dev]), 32'd0);
		wait_for_irq(dev);
		transfer(1'b0, {adr[31:16], `CH_REG_RXDATA}, 32'd0, rd);
		check_value("wbs_rsp_o.dat second byte", rd, 32'(second));
	endtask

	task automatic run_case(input int i);
		logic [31:0] rd;
		int errors_before;
		errors_before = error_count;
		case (op_q[i])
			32'd0: begin
				transfer(1'b1, adr_q[i], wdat_q[i], rd);
				if (adr_q[i][31:28] == `CH_USER_SPACE && adr_q[i][27:24] != `CH_HOST_PERIPH) begin
					check_value("caravel_req_o.we", 32'(seen_req.we), 32'd1);
					check_value("caravel_req_o.sel", 32'(seen_req.sel), 32'hF);
					check_value("caravel_req_o.adr", seen_req.adr, {4'h0, adr_q[i][27:0]});
					check_value("caravel_req_o.dat", seen_req.dat, wdat_q[i]);
				end
			end
			32'd1: begin
				transfer(1'b0, adr_q[i], wdat_q[i], rd);
				check_value("wbs_rsp_o.dat", rd, exp_q[i]);
			end
			32'd2: single_loopback(adr_q[i]);
			32'd3: double_loopback(adr_q[i]);
			default: begin
				error_count++;
				$display("Unknown op code %0d in case %0d", op_q[i], i);
			end
		endcase
		$display("case %0d op %0d adr %h: %s", i, op_q[i], adr_q[i],
			error_count == errors_before ? "ok" : "failed");
	endtask

	initial begin
		load_cases(loaded);
		if (!loaded) begin
			$display("Could not read any case from verif/caravel_host_cases.txt");
			$display("FAIL: see errors above");
			$finish;
		end else begin
			apply_reset();
			verify_reset_state();
			for (int i = 0; i < op_q.size(); i++) begin
				run_case(i);
			end
			$display("%0d cases, %0d checks, %0d errors", op_q.size(), check_count,
				error_count);
			if (error_count == 0) begin
				$display("PASS: all tests");
			end else begin
				$display("FAIL: see errors above");
			end
			$finish;
		end
	end

endmodule

// File: logic/caravel_host.sv
`timescale 1ns/10ps
`include "caravel_host_defines.svh"

module caravel_host (
	input logic wb_clk_i,
	input logic reset_i,
	input caravel_host_pkg::wb_req_t wbs_req_i,
	output caravel_host_pkg::wb_rsp_t wbs_rsp_o,
	output caravel_host_pkg::wb_req_t caravel_req_o,
	input caravel_host_pkg::wb_rsp_t caravel_rsp_i,
	input logic [`CH_NUM_UARTS-1:0] uart_rx_i,
	output logic [`CH_NUM_UARTS-1:0] uart_tx_o,
	output logic [3:0] irq_o
);

	caravel_host_pkg::wb_req_t periph_req;
	caravel_host_pkg::wb_rsp_t periph_rsp;
	caravel_host_pkg::pbus_req_t pbus_req;
	caravel_host_pkg::pbus_rsp_t pbus_rsp;
	caravel_host_pkg::pbus_rsp_t dev_rsp [`CH_NUM_UARTS];
	logic [`CH_NUM_UARTS-1:0] dev_irq;

	wb_address_router u_router (
		.wb_clk_i(wb_clk_i),
		.reset_i(reset_i),
		.host_req_i(wbs_req_i),
		.host_rsp_o(wbs_rsp_o),
		.user_req_o(caravel_req_o),
		.user_rsp_i(caravel_rsp_i),
		.periph_req_o(periph_req),
		.periph_rsp_i(periph_rsp)
	);

	wb_peripheral_bridge u_bridge (
		.wb_clk_i(wb_clk_i),
		.reset_i(reset_i),
		.wb_req_i(periph_req),
		.wb_rsp_o(periph_rsp),
		.pbus_req_o(pbus_req),
		.pbus_rsp_i(pbus_rsp)
	);

	// One UART per device index, starting at 0
	for (genvar i = 0; i < `CH_NUM_UARTS; i++) begin : g_uart
		uart_device #(
			.DEVICE_INDEX(i)
		) u_uart (
			.wb_clk_i(wb_clk_i),
			.reset_i(reset_i),
			.pbus_req_i(pbus_req),
			.pbus_rsp_o(dev_rsp[i]),
			.uart_rx_i(uart_rx_i[i]),
			.uart_tx_o(uart_tx_o[i]),
			.irq_o(dev_irq[i])
		);
	end

	peripheral_read_collector u_collector (
		.wb_clk_i(wb_clk_i),
		.reset_i(reset_i),
		.pbus_req_i(pbus_req),
		.dev_rsp_i(dev_rsp),
		.pbus_rsp_o(pbus_rsp),
		.dev_irq_i(dev_irq),
		.irq_o(irq_o)
	);

endmodule

// File: logic/peripheral_read_collector.sv
`timescale 1ns/10ps
`include "caravel_host_defines.svh"

module peripheral_read_collector (
	input logic wb_clk_i,
	input logic reset_i,
	input caravel_host_pkg::pbus_req_t pbus_req_i,
	input caravel_host_pkg::pbus_rsp_t dev_rsp_i [`CH_NUM_UARTS],
	output caravel_host_pkg::pbus_rsp_t pbus_rsp_o,
	input logic [`CH_NUM_UARTS-1:0] dev_irq_i,
	output logic [3:0] irq_o
);

	logic dev_absent;

	assign dev_absent = pbus_req_i.dev >= 4'(`CH_NUM_UARTS);

	// Unselected devices drive zeros, so a plain OR merges them
	always_comb begin
		pbus_rsp_o = '0;
		for (int i = 0; i < `CH_NUM_UARTS; i++) begin
			pbus_rsp_o.busy = pbus_rsp_o.busy | dev_rsp_i[i].busy;
			pbus_rsp_o.rdata = pbus_rsp_o.rdata | dev_rsp_i[i].rdata;
		end
		if (dev_absent) begin
			pbus_rsp_o.rdata = '1;
		end
	end

	// Unused interrupt bits stay zero
	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			irq_o <= '0;
		end else begin
			irq_o <= 4'(dev_irq_i);
		end
	end

endmodule

// File: logic/uart_device.sv
`timescale 1ns/10ps
`include "caravel_host_defines.svh"

module uart_device #(
	parameter int DEVICE_INDEX = 0
) (
	input logic wb_clk_i,
	input logic reset_i,
	input caravel_host_pkg::pbus_req_t pbus_req_i,
	output caravel_host_pkg::pbus_rsp_t pbus_rsp_o,
	input logic uart_rx_i,
	output logic uart_tx_o,
	output logic irq_o
);

	logic dev_sel;
	logic tx_write;
	logic tx_queue;
	logic tx_tick;
	logic tx_busy;
	logic [15:0] divider;
	caravel_host_pkg::uart_tx_state_e tx_state;
	logic [15:0] tx_cnt;
	logic [2:0] tx_bit;
	logic [7:0] tx_shift;
	logic [7:0] tx_hold;
	logic tx_pending;
	logic rx_meta;
	logic rx_sync;
	logic rx_last;
	logic rx_active;
	logic [15:0] rx_cnt;
	logic [3:0] rx_bit;
	logic [7:0] rx_shift;
	logic [7:0] rx_data;
	logic rx_valid;

	assign dev_sel = pbus_req_i.dev == 4'(DEVICE_INDEX);
	assign tx_write = dev_sel && pbus_req_i.we && pbus_req_i.sel[0]
		&& (pbus_req_i.addr == `CH_REG_TXDATA);
	// Second byte waits in tx_hold while a frame is on the line
	assign tx_queue = tx_write && (tx_state != caravel_host_pkg::TX_IDLE) && !tx_pending;
	assign tx_tick = tx_cnt == divider - 16'd1;
	assign tx_busy = (tx_state != caravel_host_pkg::TX_IDLE) || tx_pending;

	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			divider <= 16'(`CH_UART_DEFAULT_DIV);
		end else if (dev_sel && pbus_req_i.we && pbus_req_i.addr == `CH_REG_DIVIDER) begin
			if (pbus_req_i.sel[0]) begin
				divider[7:0] <= pbus_req_i.wdata[7:0];
			end
			if (pbus_req_i.sel[1]) begin
				divider[15:8] <= pbus_req_i.wdata[15:8];
			end
		end
	end

	// Transmit FSM, start bit, 8 data bits LSB first, stop bit
	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			tx_state <= caravel_host_pkg::TX_IDLE;
			tx_pending <= 1'b0;
			tx_cnt <= '0;
			tx_bit <= '0;
		end else begin
			if (tx_queue) begin
				tx_pending <= 1'b1;
			end
			tx_cnt <= tx_tick ? 16'd0 : tx_cnt + 16'd1;
			case (tx_state)
				caravel_host_pkg::TX_IDLE: begin
					tx_cnt <= '0;
					if (tx_write || tx_pending) begin
						tx_pending <= 1'b0;
						tx_state <= caravel_host_pkg::TX_START;
					end
				end
				caravel_host_pkg::TX_START: begin
					if (tx_tick) begin
						tx_bit <= '0;
						tx_state <= caravel_host_pkg::TX_DATA;
					end
				end
				caravel_host_pkg::TX_DATA: begin
					if (tx_tick) begin
						tx_bit <= tx_bit + 3'd1;
						if (tx_bit == 3'd7) begin
							tx_state <= caravel_host_pkg::TX_STOP;
						end
					end
				end
				default: begin
					if (tx_tick && tx_pending) begin
						tx_pending <= 1'b0;
						tx_state <= caravel_host_pkg::TX_START;
					end else if (tx_tick) begin
						tx_state <= caravel_host_pkg::TX_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (tx_queue) begin
			tx_hold <= pbus_req_i.wdata[7:0];
		end
		if (tx_state == caravel_host_pkg::TX_IDLE) begin
			tx_shift <= tx_write ? pbus_req_i.wdata[7:0] : tx_hold;
		end else if (tx_state == caravel_host_pkg::TX_STOP && tx_tick) begin
			tx_shift <= tx_hold;
		end else if (tx_state == caravel_host_pkg::TX_DATA && tx_tick) begin
			tx_shift <= tx_shift >> 1;
		end
	end

	always_comb begin
		case (tx_state)
			caravel_host_pkg::TX_START: uart_tx_o = 1'b0;
			caravel_host_pkg::TX_DATA: uart_tx_o = tx_shift[0];
			default: uart_tx_o = 1'b1;
		endcase
	end

	// Receiver, bit 0 is the start bit and bit 9 the stop bit
	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_last <= 1'b1;
			rx_active <= 1'b0;
			rx_valid <= 1'b0;
			rx_cnt <= '0;
			rx_bit <= '0;
		end else begin
			rx_meta <= uart_rx_i;
			rx_sync <= rx_meta;
			rx_last <= rx_sync;
			if (dev_sel && pbus_req_i.oe && pbus_req_i.addr == `CH_REG_RXDATA) begin
				rx_valid <= 1'b0;
			end
			if (!rx_active) begin
				if (rx_last && !rx_sync) begin
					// Half a bit to land mid start bit
					rx_active <= 1'b1;
					rx_cnt <= divider >> 1;
					rx_bit <= '0;
				end
			end else if (rx_cnt != 16'd0) begin
				rx_cnt <= rx_cnt - 16'd1;
			end else begin
				rx_cnt <= divider - 16'd1;
				rx_bit <= rx_bit + 4'd1;
				if (rx_bit == 4'd0 && rx_sync) begin
					rx_active <= 1'b0;
				end else if (rx_bit == 4'd9) begin
					rx_active <= 1'b0;
					if (rx_sync) begin
						rx_valid <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (rx_active && rx_cnt == 16'd0) begin
			if (rx_bit >= 4'd1 && rx_bit <= 4'd8) begin
				rx_shift <= {rx_sync, rx_shift[7:1]};
			end else if (rx_bit == 4'd9 && rx_sync) begin
				rx_data <= rx_shift;
			end
		end
	end

	always_comb begin
		pbus_rsp_o.busy = dev_sel && tx_pending;
		pbus_rsp_o.rdata = '0;
		if (dev_sel) begin
			case (pbus_req_i.addr)
				`CH_REG_STATUS: pbus_rsp_o.rdata = {30'd0, rx_valid, tx_busy};
				`CH_REG_RXDATA: pbus_rsp_o.rdata = {24'd0, rx_data};
				`CH_REG_DIVIDER: pbus_rsp_o.rdata = {16'd0, divider};
				default: pbus_rsp_o.rdata = '0;
			endcase
		end
	end

	assign irq_o = rx_valid;

endmodule

// File: logic/wb_peripheral_bridge.sv
`timescale 1ns/10ps
`include "caravel_host_defines.svh"

module wb_peripheral_bridge (
	input logic wb_clk_i,
	input logic reset_i,
	input caravel_host_pkg::wb_req_t wb_req_i,
	output caravel_host_pkg::wb_rsp_t wb_rsp_o,
	output caravel_host_pkg::pbus_req_t pbus_req_o,
	input caravel_host_pkg::pbus_rsp_t pbus_rsp_i
);

	caravel_host_pkg::bridge_state_e state;
	logic we_q;
	logic [19:0] adr_q;
	logic [3:0] sel_q;
	logic [`CH_WB_DATA_W-1:0] wdata_q;
	logic [`CH_WB_DATA_W-1:0] rdata_q;

	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			state <= caravel_host_pkg::BR_IDLE;
			we_q <= 1'b0;
		end else begin
			case (state)
				caravel_host_pkg::BR_IDLE: begin
					if (wb_req_i.cyc && wb_req_i.stb) begin
						we_q <= wb_req_i.we;
						state <= caravel_host_pkg::BR_ACCESS;
					end
				end
				caravel_host_pkg::BR_ACCESS: begin
					state <= caravel_host_pkg::BR_WAIT;
				end
				// Device holds busy while it cannot take the access
				caravel_host_pkg::BR_WAIT: begin
					if (!pbus_rsp_i.busy) begin
						state <= caravel_host_pkg::BR_ACK;
					end
				end
				default: begin
					state <= caravel_host_pkg::BR_IDLE;
				end
			endcase
		end
	end

	// Request payload and captured read data
	always_ff @(posedge wb_clk_i) begin
		if (state == caravel_host_pkg::BR_IDLE && wb_req_i.cyc && wb_req_i.stb) begin
			adr_q <= wb_req_i.adr[19:0];
			sel_q <= wb_req_i.sel;
			wdata_q <= wb_req_i.dat;
		end
		if (state == caravel_host_pkg::BR_WAIT && !pbus_rsp_i.busy) begin
			rdata_q <= pbus_rsp_i.rdata;
		end
	end

	// Single strobe per cycle, only in BR_ACCESS
	always_comb begin
		pbus_req_o.we = (state == caravel_host_pkg::BR_ACCESS) && we_q;
		pbus_req_o.oe = (state == caravel_host_pkg::BR_ACCESS) && !we_q;
		pbus_req_o.dev = adr_q[19:16];
		pbus_req_o.addr = adr_q[15:0];
		pbus_req_o.sel = sel_q;
		pbus_req_o.wdata = wdata_q;
	end

	always_comb begin
		wb_rsp_o.ack = state == caravel_host_pkg::BR_ACK;
		wb_rsp_o.err = 1'b0;
		wb_rsp_o.dat = rdata_q;
	end

endmodule

// File: logic/wb_address_router.sv
`timescale 1ns/10ps
`include "caravel_host_defines.svh"

module wb_address_router (
	input logic wb_clk_i,
	input logic reset_i,
	input caravel_host_pkg::wb_req_t host_req_i,
	output caravel_host_pkg::wb_rsp_t host_rsp_o,
	output caravel_host_pkg::wb_req_t user_req_o,
	input caravel_host_pkg::wb_rsp_t user_rsp_i,
	output caravel_host_pkg::wb_req_t periph_req_o,
	input caravel_host_pkg::wb_rsp_t periph_rsp_i
);

	logic user_space;
	logic host_select;
	logic host_latch;
	caravel_host_pkg::route_e route;

	assign user_space = host_req_i.adr[31:28] == `CH_USER_SPACE;
	assign host_select = user_space && (host_req_i.adr[27:24] == `CH_HOST_PERIPH);

	// Keep a host cycle on the host path until cyc drops
	always_ff @(posedge wb_clk_i) begin
		if (reset_i || !host_req_i.cyc) begin
			host_latch <= 1'b0;
		end else if (host_select) begin
			host_latch <= 1'b1;
		end
	end

	always_comb begin
		if (host_latch || host_select) begin
			route = caravel_host_pkg::ROUTE_HOST;
		end else if (user_space) begin
			route = caravel_host_pkg::ROUTE_USER;
		end else begin
			route = caravel_host_pkg::ROUTE_NONE;
		end
	end

	// Outgoing master sees only the low 28 address bits
	always_comb begin
		user_req_o = '0;
		if (route == caravel_host_pkg::ROUTE_USER) begin
			user_req_o = host_req_i;
			user_req_o.adr = {4'h0, host_req_i.adr[27:0]};
		end
	end

	always_comb begin
		periph_req_o = '0;
		if (route == caravel_host_pkg::ROUTE_HOST) begin
			periph_req_o = host_req_i;
		end
	end

	always_comb begin
		host_rsp_o = '0;
		if (host_req_i.cyc) begin
			case (route)
				caravel_host_pkg::ROUTE_HOST: begin
					host_rsp_o.ack = periph_rsp_i.ack;
					host_rsp_o.dat = periph_rsp_i.dat;
				end
				// Error from the user area still ends the cycle
				caravel_host_pkg::ROUTE_USER: begin
					host_rsp_o.ack = user_rsp_i.ack || user_rsp_i.err;
					host_rsp_o.dat = user_rsp_i.dat;
				end
				default: begin
					host_rsp_o.ack = host_req_i.stb;
				end
			endcase
		end
	end

endmodule

// File: logic/caravel_host_pkg.sv
package caravel_host_pkg;

`include "caravel_host_defines.svh"

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [3:0] sel;
		logic [`CH_WB_ADDR_W-1:0] adr;
		logic [`CH_WB_DATA_W-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		logic err;
		logic [`CH_WB_DATA_W-1:0] dat;
	} wb_rsp_t;

	// Peripheral bus, one access per we or oe pulse
	typedef struct packed {
		logic we;
		logic oe;
		logic [3:0] dev;
		logic [`CH_PBUS_ADDR_W-1:0] addr;
		logic [3:0] sel;
		logic [`CH_WB_DATA_W-1:0] wdata;
	} pbus_req_t;

	typedef struct packed {
		logic busy;
		logic [`CH_WB_DATA_W-1:0] rdata;
	} pbus_rsp_t;

	typedef enum logic [1:0] {ROUTE_NONE, ROUTE_USER, ROUTE_HOST} route_e;
	typedef enum logic [1:0] {BR_IDLE, BR_ACCESS, BR_WAIT, BR_ACK} bridge_state_e;
	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} uart_tx_state_e;

endpackage

// File: include/caravel_host_defines.svh
`ifndef CARAVEL_HOST_DEFINES_SVH
`define CARAVEL_HOST_DEFINES_SVH

// Address map nibbles, bits 31:28 and 27:24
`define CH_USER_SPACE 4'h3
`define CH_HOST_PERIPH 4'hF

// Bus widths
`define CH_WB_ADDR_W 32
`define CH_WB_DATA_W 32
`define CH_PBUS_ADDR_W 16

// UART instances, 1 to 4
`define CH_NUM_UARTS 2
`define CH_UART_DEFAULT_DIV 16

// Local register offsets inside one UART
`define CH_REG_STATUS 16'h0000
`define CH_REG_TXDATA 16'h0004
`define CH_REG_RXDATA 16'h0008
`define CH_REG_DIVIDER 16'h000C

`endif
